/* hw/dec_8b10b_config.svh */
// --------------------------------------
// Width and reset constants shared by
// the 8b/10b decoder blocks
// --------------------------------------

`ifndef DEC_8B10B_CONFIG_SVH
`define DEC_8B10B_CONFIG_SVH

// Line code sizes
`define DEC_SYM_W   10      // Full symbol, abcdei fghj
`define DEC_G6_W    6       // abcdei group
`define DEC_G4_W    4       // fghj group

// Decoded fields
`define DEC_D5_W    5       // EDCBA
`define DEC_D3_W    3       // HGF
`define DEC_BYTE_W  8       // HGFEDCBA

// Running disparity after reset, 0 is negative
`define DEC_RD_RST  1'b0

`endif

/* hw/dec_8b10b_pkg.sv */
// --------------------------------------
// Types shared by the 8b/10b decoder
// --------------------------------------

package dec_8b10b_pkg;

    // --------------------------------------
    // Running disparity
    // --------------------------------------
    typedef enum logic {
        RD_NEG = 1'b0,          // More zeros sent so far
        RD_POS = 1'b1           // More ones sent so far
    } disp_e;

    // --------------------------------------
    // Sub-block code group class
    // --------------------------------------
    // Derived from the ones count of a legal
    // group, illegal patterns map to invalid
    typedef enum logic [1:0] {
        GRP_NEUTRAL = 2'b00,    // Balanced, rd unchanged
        GRP_POS     = 2'b01,    // Surplus of ones
        GRP_NEG     = 2'b10,    // Surplus of zeros
        GRP_INVALID = 2'b11     // Not in the code table
    } grp_class_e;

endpackage : dec_8b10b_pkg

/* hw/dec_6b5b.sv */
// --------------------------------------
// 6b to 5b decoder for the abcdei group,
// with group class and K28 markers
// --------------------------------------

`include "dec_8b10b_config.svh"

module dec_6b5b
    import dec_8b10b_pkg::*;
(
    input  logic [`DEC_G6_W-1:0] g6,            // a in the MSB
    output logic [`DEC_D5_W-1:0] d5,            // EDCBA
    output grp_class_e           class6,
    output logic                 k28,
    output logic                 k28_pos_form   // 110000 seen
);

    logic                 hit;
    logic [`DEC_D5_W-1:0] code;
    logic [2:0]           ones;

    assign ones = 3'($countones(g6));

    // --------------------------------------
    // 5b/6b code table, both rd columns
    // --------------------------------------
    always_comb begin
        hit  = 1'b1;
        code = '0;
        case (g6)
            6'b100111, 6'b011000: code = 5'd0;
            6'b011101, 6'b100010: code = 5'd1;
            6'b101101, 6'b010010: code = 5'd2;
            6'b110001:            code = 5'd3;
            6'b110101, 6'b001010: code = 5'd4;
            6'b101001:            code = 5'd5;
            6'b011001:            code = 5'd6;
            6'b111000, 6'b000111: code = 5'd7;
            6'b111001, 6'b000110: code = 5'd8;
            6'b100101:            code = 5'd9;
            6'b010101:            code = 5'd10;
            6'b110100:            code = 5'd11;
            6'b001101:            code = 5'd12;
            6'b101100:            code = 5'd13;
            6'b011100:            code = 5'd14;
            6'b010111, 6'b101000: code = 5'd15;
            6'b011011, 6'b100100: code = 5'd16;
            6'b100011:            code = 5'd17;
            6'b010011:            code = 5'd18;
            6'b110010:            code = 5'd19;
            6'b001011:            code = 5'd20;
            6'b101010:            code = 5'd21;
            6'b011010:            code = 5'd22;
            6'b111010, 6'b000101: code = 5'd23;
            6'b110011, 6'b001100: code = 5'd24;
            6'b100110:            code = 5'd25;
            6'b010110:            code = 5'd26;
            6'b110110, 6'b001001: code = 5'd27;
            6'b001110:            code = 5'd28;
            6'b001111, 6'b110000: code = 5'd28;     // K28 forms
            6'b101110, 6'b010001: code = 5'd29;
            6'b011110, 6'b100001: code = 5'd30;
            6'b101011, 6'b010100: code = 5'd31;
            default:              hit  = 1'b0;      // 111100, 000011 and counts 0,1,5,6
        endcase
    end

    assign d5 = code;

    // --------------------------------------
    // Class by ones count
    // --------------------------------------
    always_comb begin
        if (!hit) begin
            class6 = GRP_INVALID;
        end else begin
            case (ones)
                3'd2:    class6 = GRP_NEG;
                3'd3:    class6 = GRP_NEUTRAL;
                3'd4:    class6 = GRP_POS;
                default: class6 = GRP_INVALID;
            endcase
        end
    end

    assign k28_pos_form = (g6 == 6'b110000);
    assign k28          = (g6 == 6'b001111) || k28_pos_form;

    // An illegal group must not leak a data value downstream
    always_comb begin
        assert (class6 != GRP_INVALID || d5 == '0)
            else $error("dec_6b5b: nonzero EDCBA %0h on invalid group %b", d5, g6);
    end

endmodule : dec_6b5b

/* hw/dec_4b3b.sv */
// --------------------------------------
// 4b to 3b decoder for the fghj group,
// with K28 complement and A7 marker
// --------------------------------------

`include "dec_8b10b_config.svh"

module dec_4b3b
    import dec_8b10b_pkg::*;
(
    input  logic [`DEC_G4_W-1:0] g4,            // f in the MSB
    input  logic                 k28_pos_form,
    output logic [`DEC_D3_W-1:0] d3,            // HGF
    output grp_class_e           class4,
    output logic                 alt7
);

    logic                 hit;
    logic                 flip;
    logic [`DEC_D3_W-1:0] code;
    logic [2:0]           ones;

    assign ones = 3'($countones(g4));

    // --------------------------------------
    // 3b/4b code table
    // --------------------------------------
    always_comb begin
        hit  = 1'b1;
        flip = 1'b0;
        code = '0;
        case (g4)
            4'b1011, 4'b0100: code = 3'd0;
            4'b1001: begin
                code = 3'd1;
                flip = 1'b1;
            end
            4'b0101: begin
                code = 3'd2;
                flip = 1'b1;
            end
            4'b1100, 4'b0011: code = 3'd3;
            4'b1101, 4'b0010: code = 3'd4;
            4'b1010: begin
                code = 3'd5;
                flip = 1'b1;
            end
            4'b0110: begin
                code = 3'd6;
                flip = 1'b1;
            end
            4'b1110, 4'b0001: code = 3'd7;          // Primary 7
            4'b0111, 4'b1000: code = 3'd7;          // Alternate 7
            default:          hit  = 1'b0;
        endcase
    end

    // After 110000 the balanced pairs swap meaning
    assign d3 = (flip && k28_pos_form) ? ~code : code;

    always_comb begin
        if (!hit) begin
            class4 = GRP_INVALID;
        end else begin
            case (ones)
                3'd1:    class4 = GRP_NEG;
                3'd2:    class4 = GRP_NEUTRAL;
                3'd3:    class4 = GRP_POS;
                default: class4 = GRP_INVALID;
            endcase
        end
    end

    assign alt7 = (g4 == 4'b0111) || (g4 == 4'b1000);

endmodule : dec_4b3b

/* hw/dec_combine.sv */
// --------------------------------------
// Control detection, running disparity,
// error flags and the output register
// --------------------------------------

`include "dec_8b10b_config.svh"

module dec_combine
    import dec_8b10b_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`DEC_D5_W-1:0]   d5,
    input  grp_class_e             class6,
    input  logic                   k28,
    input  logic [`DEC_D3_W-1:0]   d3,
    input  grp_class_e             class4,
    input  logic                   alt7,
    output logic [`DEC_BYTE_W-1:0] data,
    output logic                   k,
    output logic                   code_err,
    output logic                   disp_err,
    output disp_e                  rd
);

    disp_e rd_mid;                  // rd between the two groups
    disp_e rd_next;
    logic  derr6;
    logic  derr4;
    logic  k_alt;
    logic  k_nxt;
    logic  alt7_ok;
    logic  cerr_nxt;

    function automatic disp_e rd_after(input disp_e rd_in, input grp_class_e cls);
        disp_e rd_out;
        case (cls)
            GRP_POS: rd_out = RD_POS;
            GRP_NEG: rd_out = RD_NEG;
            default: rd_out = rd_in;
        endcase
        return rd_out;
    endfunction

    function automatic logic disp_clash(input disp_e rd_in, input grp_class_e cls);
        return ((cls == GRP_POS) && (rd_in == RD_POS)) ||
               ((cls == GRP_NEG) && (rd_in == RD_NEG));
    endfunction

    // --------------------------------------
    // Disparity, 6b group first
    // --------------------------------------
    assign rd_mid  = rd_after(rd, class6);
    assign rd_next = rd_after(rd_mid, class4);
    assign derr6   = disp_clash(rd, class6);
    assign derr4   = disp_clash(rd_mid, class4);

    // --------------------------------------
    // Control and A7 legality
    // --------------------------------------
    assign k_alt = alt7 && (d5 inside {5'd23, 5'd27, 5'd29, 5'd30});
    assign k_nxt = k28 || k_alt;

    always_comb begin
        if (rd_mid == RD_NEG) begin
            alt7_ok = (d5 == 5'd17) || (d5 == 5'd18) || (d5 == 5'd20);
        end else begin
            alt7_ok = (d5 == 5'd11) || (d5 == 5'd13) || (d5 == 5'd14);
        end
    end

    assign cerr_nxt = (class6 == GRP_INVALID) ||
                      (class4 == GRP_INVALID) ||
                      (alt7 && !k_nxt && !alt7_ok);    // A7 after the wrong x

    // --------------------------------------
    // Output register
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data     <= '0;
            k        <= 1'b0;
            code_err <= 1'b0;
            disp_err <= 1'b0;
            rd       <= disp_e'(`DEC_RD_RST);
        end else begin
            data     <= cerr_nxt ? '0 : {d3, d5};
            k        <= k_nxt && !cerr_nxt;
            code_err <= cerr_nxt;
            disp_err <= derr6 || derr4;
            if (!cerr_nxt) begin
                rd <= rd_next;                          // Held on a code error
            end
        end
    end

    // --------------------------------------
    // Assertions
    // --------------------------------------
    a_k_not_err: assert property (@(posedge clk) disable iff (!rst_n)
        !(k && code_err))
        else $error("dec_combine: k raised with code_err");

    a_rd_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(rd))
        else $error("dec_combine: rd unknown");

endmodule : dec_combine

/* hw/dec_8b10b_top.sv */
// --------------------------------------
// Registered 8b/10b decoder top level
// --------------------------------------

`include "dec_8b10b_config.svh"

module dec_8b10b_top
    import dec_8b10b_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`DEC_SYM_W-1:0]  symbol,     // abcdei fghj, a in the MSB
    output logic [`DEC_BYTE_W-1:0] data,
    output logic                   k,
    output logic                   code_err,
    output logic                   disp_err,
    output disp_e                  rd
);

    logic [`DEC_D5_W-1:0] d5;
    grp_class_e           class6;
    logic                 k28;
    logic                 k28_pos_form;
    logic [`DEC_D3_W-1:0] d3;
    grp_class_e           class4;
    logic                 alt7;

    dec_6b5b u_dec_6b5b (
        .g6           (symbol[`DEC_SYM_W-1:`DEC_G4_W]),
        .d5           (d5),
        .class6       (class6),
        .k28          (k28),
        .k28_pos_form (k28_pos_form)
    );

    dec_4b3b u_dec_4b3b (
        .g4           (symbol[`DEC_G4_W-1:0]),
        .k28_pos_form (k28_pos_form),
        .d3           (d3),
        .class4       (class4),
        .alt7         (alt7)
    );

    dec_combine u_dec_combine (
        .clk      (clk),
        .rst_n    (rst_n),
        .d5       (d5),
        .class6   (class6),
        .k28      (k28),
        .d3       (d3),
        .class4   (class4),
        .alt7     (alt7),
        .data     (data),
        .k        (k),
        .code_err (code_err),
        .disp_err (disp_err),
        .rd       (rd)
    );

endmodule : dec_8b10b_top

/* verification/tb_dec_8b10b.sv */
// --------------------------------------
// Testbench for the 8b/10b decoder with
// golden-file stimulus and checking
// --------------------------------------

`include "dec_8b10b_config.svh"

module tb_dec_8b10b;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_ENT = 64;
    localparam int FIELDS  = 7;        // test, symbol, data, k, code_err, disp_err, rd

    logic                   clk;
    logic                   rst_n;
    logic [`DEC_SYM_W-1:0]  symbol;
    logic [`DEC_BYTE_W-1:0] data;
    logic                   k;
    logic                   code_err;
    logic                   disp_err;
    logic                   rd;

    logic [11:0] gold [0:MAX_ENT*FIELDS-1];
    int          n_ent;
    int          cycles;
    int          limit;
    int          pass_cnt;
    int          fail_cnt;
    int          test_err;
    int          test_syms;

    dec_8b10b_top u_dec_8b10b_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .symbol   (symbol),
        .data     (data),
        .k        (k),
        .code_err (code_err),
        .disp_err (disp_err),
        .rd       (rd)
    );

    always #20 clk = ~clk;

    // --------------------------------------
    // Timeout
    // --------------------------------------
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Run timed out after %0d cycles without finishing", cycles);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [11:0] field(input int idx, input int f);
        return gold[idx*FIELDS+f];
    endfunction

    function automatic logic [`DEC_SYM_W-1:0] symbol_at(input int idx);
        logic [11:0] word;
        word = gold[idx*FIELDS+1];
        return word[`DEC_SYM_W-1:0];
    endfunction

    task automatic check_value(input string name, input logic [11:0] got,
                               input logic [11:0] exp);
        assert (got === exp) begin
            pass_cnt++;
        end else begin
            $display("[ERROR] %s got %0h expected %0h", name, got, exp);
            fail_cnt++;
            test_err++;
        end
    endtask

    task automatic check_outputs(input logic [11:0] e_data, input logic [11:0] e_k,
                                 input logic [11:0] e_ce, input logic [11:0] e_de,
                                 input logic [11:0] e_rd);
        check_value("data", {4'h0, data}, e_data);
        check_value("k", {11'h0, k}, e_k);
        check_value("code_err", {11'h0, code_err}, e_ce);
        check_value("disp_err", {11'h0, disp_err}, e_de);
        check_value("rd", {11'h0, rd}, e_rd);
    endtask

    task automatic report_test(input int num);
        $display("Test %0d finished: %0d symbols, %0d errors", num, test_syms, test_err);
        test_err  = 0;
        test_syms = 0;
    endtask

    // --------------------------------------
    // Stimulus and checking
    // --------------------------------------
    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        symbol    = 10'b1010101010;     // D.21.5 while in reset
        cycles    = 0;
        limit     = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        test_err  = 0;
        test_syms = 0;
        n_ent     = 0;

        for (int i = 0; i < MAX_ENT*FIELDS; i++) begin
            gold[i] = '0;
        end
        $readmemh("verification/dec_8b10b_golden.txt", gold);
        while (n_ent < MAX_ENT && field(n_ent, 0) != 0) begin
            n_ent++;
        end
        if (n_ent == 0) begin
            $display("Golden file holds no entries");
            fail_cnt++;
        end
        limit = 8 + n_ent + 20;

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Outputs still hold the reset values here
        check_outputs(12'h0, 12'h0, 12'h0, 12'h0, 12'h0);
        report_test(1);

        if (n_ent > 0) begin
            symbol = symbol_at(0);
        end
        for (int i = 1; i <= n_ent; i++) begin
            @(posedge clk);
            #2;
            check_outputs(field(i-1, 2), field(i-1, 3), field(i-1, 4),
                          field(i-1, 5), field(i-1, 6));
            test_syms++;
            if (i == n_ent || field(i, 0) != field(i-1, 0)) begin
                report_test(int'(field(i-1, 0)));
            end
            if (i < n_ent) begin
                symbol = symbol_at(i);
            end
        end

        $display("Checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : tb_dec_8b10b

/* verification/dec_8b10b_golden.txt */
// Columns: test symbol(abcdei fghj) data k code_err disp_err rd, all hex
// A test number of 0 ends the list
// Test 2 data characters
02 274 00 0 0 0 0
02 2AA B5 0 0 0 0
02 2B1 FF 0 0 0 0
02 31B 03 0 0 0 1
02 18B 00 0 0 0 1
02 14E FF 0 0 0 1
// Test 3 control characters
03 30B 1C 1 0 0 1
03 306 3C 1 0 0 0
03 0F9 3C 1 0 0 1
03 30A 5C 1 0 0 0
03 0F5 5C 1 0 0 1
03 30C 7C 1 0 0 0
03 0F3 7C 1 0 0 1
03 30D 9C 1 0 0 1
03 305 BC 1 0 0 0
03 0FA BC 1 0 0 1
03 309 DC 1 0 0 0
03 0F6 DC 1 0 0 1
03 307 FC 1 0 0 1
03 057 F7 1 0 0 1
03 097 FB 1 0 0 1
03 117 FD 1 0 0 1
03 217 FE 1 0 0 1
03 306 3C 1 0 0 0
03 0F4 1C 1 0 0 0
03 0F2 9C 1 0 0 0
03 0F8 FC 1 0 0 0
03 3A8 F7 1 0 0 0
// Test 4 alternate 7
04 237 F1 0 0 0 1
04 348 EB 0 0 0 0
04 0B7 F4 0 0 0 1
04 1C8 EE 0 0 0 0
04 297 00 0 1 0 0
04 347 00 0 1 0 0
04 137 F2 0 0 0 1
04 238 00 0 1 0 1
04 2C8 ED 0 0 0 0
// Test 5 invalid groups
05 3FB 00 0 1 0 0
05 2A0 00 0 1 0 0
05 000 00 0 1 0 0
05 3CA 00 0 1 0 0
05 0FF 00 0 1 0 0
05 2AA B5 0 0 0 0
// Test 6 disparity errors
06 274 00 0 0 0 0
06 27B 00 0 0 1 1
06 274 00 0 0 1 0
06 18B 00 0 0 1 1
06 2AA B5 0 0 0 1
00 000 00 0 0 0 0

/* build.f */
+incdir+hw
hw/dec_8b10b_pkg.sv
hw/dec_6b5b.sv
hw/dec_4b3b.sv
hw/dec_combine.sv
hw/dec_8b10b_top.sv
verification/tb_dec_8b10b.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_dec_8b10b
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard hw/*.sv hw/*.svh verification/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) verification/dec_8b10b_golden.txt
	./$(SIM_BIN) > $(LOG); cat $(LOG)
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
